// File: flist.f
source/tl_pkg.sv
source/dcache_tag_array.sv
source/store_buffer.sv
source/tl_hazard_ctrl.sv
source/tl_stage.sv
tb/tl_stage_asserts.sv
tb/tl_stage_checker.sv
tb/tl_stage_tb.sv

// File: Makefile
TOP = tl_stage_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f --Mdir obj_dir -o sim

run: compile
	./obj_dir/sim +verilator+error+limit+1000 | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then echo "Run failed"; exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log || (echo "Run ended without result"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: tb/tl_stage_tb.sv
`timescale 1ns/1ps

module tl_stage_tb;
    import tl_pkg::*;

    localparam time CLK_PERIOD     = 40ns;
    localparam int  RESET_CYCLES   = 16;
    localparam int  STALL_LIMIT    = 64;
    // Summed length of all tests in cycles without miss delays
    localparam int  TEST_CYCLES    = 150;
    localparam int  MAX_MISS_DELAY = 6;
    localparam int  WATCHDOG_CYCLES = TEST_CYCLES * MAX_MISS_DELAY + 200;

    logic     clk_i;
    logic     rst_n_i;
    logic     kill_i;
    logic     store_permission_i;
    logic     pipeline_hazard_o;
    logic     mmu_miss_o;
    logic     mmu_data_rdy_i;
    ex_req_t  ex_req_i;
    mem_req_t mem_o;
    addr_t    mmu_addr_o;
    addr_t    mmu_addr_i;

    int d0;
    int f0;
    int s0;
    int assert_fails;

    tl_stage tl_stage_i (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .kill_i             (kill_i),
        .ex_req_i           (ex_req_i),
        .store_permission_i (store_permission_i),
        .mem_o              (mem_o),
        .pipeline_hazard_o  (pipeline_hazard_o),
        .mmu_miss_o         (mmu_miss_o),
        .mmu_addr_o         (mmu_addr_o),
        .mmu_data_rdy_i     (mmu_data_rdy_i),
        .mmu_addr_i         (mmu_addr_i)
    );

    tl_stage_checker checker_i (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .kill_i             (kill_i),
        .ex_req_i           (ex_req_i),
        .store_permission_i (store_permission_i),
        .mem_o              (mem_o),
        .pipeline_hazard_o  (pipeline_hazard_o),
        .mmu_miss_o         (mmu_miss_o),
        .mmu_addr_o         (mmu_addr_o),
        .mmu_data_rdy_i     (mmu_data_rdy_i),
        .mmu_addr_i         (mmu_addr_i)
    );

    bind tl_stage tl_stage_asserts tl_stage_asserts_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .mmu_miss_o     (mmu_miss_o),
        .mmu_data_rdy_i (mmu_data_rdy_i),
        .mmu_addr_o     (mmu_addr_o),
        .mem_o          (mem_o),
        .state_i        (state)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    function automatic ex_req_t make_req(input logic rd, input logic wr,
                                         input memop_size_t size, input addr_t addr,
                                         input word_t data, input instr_id_t id);
        ex_req_t req;
        req = '0;
        req.rd = rd;
        req.wr = wr;
        req.sign_ext = rd && (size != 2'd2);
        req.size = size;
        req.addr = addr;
        req.data = data;
        req.rf_we = rd;
        req.rf_waddr = reg_addr_t'(id) + 5'd1;
        req.instr_id = id;
        return req;
    endfunction

    // Holds the request until the stage takes it and then drives a bubble
    task automatic issue(input ex_req_t req, input logic kill);
        int waited;
        waited = 0;
        ex_req_i = req;
        kill_i = kill;
        @(negedge clk_i);
        while (pipeline_hazard_o) begin
            waited++;
            if (waited > STALL_LIMIT) begin
                checker_i.report_error($sformatf("request to %h never accepted", req.addr));
                break;
            end
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #2;
        ex_req_i = '0;
        kill_i = 1'b0;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clk_i);
        #2;
    endtask

    // Memory unit answers each miss after 1 to 6 cycles
    initial begin : mmu_responder
        int unsigned delay;
        mmu_data_rdy_i = 1'b0;
        mmu_addr_i = '0;
        forever begin
            @(negedge clk_i);
            if (rst_n_i && mmu_miss_o) begin
                delay = 1 + ($urandom % MAX_MISS_DELAY);
                repeat (delay) @(posedge clk_i);
                #2;
                mmu_data_rdy_i = 1'b1;
                mmu_addr_i = mmu_addr_o;
                @(posedge clk_i);
                #2;
                mmu_data_rdy_i = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : stimulus
        void'($urandom(32'hc523e538));
        rst_n_i = 1'b0;
        kill_i = 1'b0;
        store_permission_i = 1'b0;
        ex_req_i = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        idle(2);

        issue(make_req(1'b1, 1'b0, 2'd2, 32'h1000_0040, '0, 3'd1), 1'b0);
        idle(2);
        checker_i.finish_test("reset and load miss");

        issue(make_req(1'b1, 1'b0, 2'd2, 32'h1000_0044, '0, 3'd2), 1'b0);
        idle(2);
        checker_i.finish_test("load hit");

        f0 = checker_i.fwd_seen;
        issue(make_req(1'b0, 1'b1, 2'd2, 32'h2000_0010, $urandom, 3'd3), 1'b0);
        issue(make_req(1'b0, 1'b1, 2'd2, 32'h2000_0010, $urandom, 3'd4), 1'b0);
        issue(make_req(1'b0, 1'b1, 2'd1, 32'h2000_0020, $urandom, 3'd5), 1'b0);
        issue(make_req(1'b1, 1'b0, 2'd2, 32'h2000_0010, '0, 3'd6), 1'b0);
        issue(make_req(1'b1, 1'b0, 2'd1, 32'h2000_0020, '0, 3'd7), 1'b0);
        store_permission_i = 1'b1;
        issue(make_req(1'b1, 1'b0, 2'd0, 32'h2000_0011, '0, 3'd0), 1'b0);
        idle(4);
        if (checker_i.fwd_seen - f0 != 2) begin
            checker_i.report_error("forwarding did not serve two loads");
        end
        checker_i.finish_test("store forwarding and conflict");

        store_permission_i = 1'b0;
        d0 = checker_i.drain_seen;
        issue(make_req(1'b0, 1'b1, 2'd2, 32'h3000_0000, $urandom, 3'd1), 1'b0);
        issue(make_req(1'b0, 1'b1, 2'd1, 32'h3000_0004, $urandom, 3'd2), 1'b0);
        issue(make_req(1'b0, 1'b1, 2'd0, 32'h3000_0008, $urandom, 3'd3), 1'b0);
        store_permission_i = 1'b1;
        idle(6);
        if (checker_i.drain_seen - d0 != 3) begin
            checker_i.report_error("bubbles did not drain exactly three stores");
        end
        checker_i.finish_test("drain order");

        store_permission_i = 1'b0;
        s0 = checker_i.stall_seen;
        for (int i = 0; i < SB_ENTRIES; i++) begin
            issue(make_req(1'b0, 1'b1, 2'd2, 32'h3000_0100 + 32'(4 * i), $urandom,
                           instr_id_t'(i)), 1'b0);
        end
        fork
            issue(make_req(1'b0, 1'b1, 2'd2, 32'h3000_0140, $urandom, 3'd7), 1'b0);
            begin
                repeat (6) @(posedge clk_i);
                #2;
                store_permission_i = 1'b1;
            end
        join
        idle(8);
        if (checker_i.stall_seen == s0) begin
            checker_i.report_error("a full store buffer did not stall the stage");
        end
        checker_i.finish_test("full buffer stall");

        store_permission_i = 1'b0;
        issue(make_req(1'b0, 1'b1, 2'd2, 32'h4000_0000, $urandom, 3'd1), 1'b0);
        issue(make_req(1'b0, 1'b1, 2'd2, 32'h4000_0004, $urandom, 3'd2), 1'b0);
        d0 = checker_i.drain_seen;
        issue(make_req(1'b1, 1'b0, 2'd2, 32'h1000_0048, '0, 3'd3), 1'b1);
        store_permission_i = 1'b1;
        idle(6);
        if (checker_i.drain_seen != d0) begin
            checker_i.report_error("stores drained after kill");
        end
        checker_i.finish_test("kill");

        assert_fails = tl_stage_i.tl_stage_asserts_i.fail_count;
        checker_i.summary(assert_fails);
        if (checker_i.errors == 0 && assert_fails == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : tl_stage_tb

// File: tb/tl_stage_checker.sv
`timescale 1ns/1ps

module tl_stage_checker (
    input logic             clk_i,
    input logic             rst_n_i,
    input logic             kill_i,
    input tl_pkg::ex_req_t  ex_req_i,
    input logic             store_permission_i,
    input tl_pkg::mem_req_t mem_o,
    input logic             pipeline_hazard_o,
    input logic             mmu_miss_o,
    input tl_pkg::addr_t    mmu_addr_o,
    input logic             mmu_data_rdy_i,
    input tl_pkg::addr_t    mmu_addr_i
);
    import tl_pkg::*;

    typedef struct packed {
        logic        rd;
        logic        wr;
        logic        sb_hit;
        logic        rf_we;
        logic        sign_ext;
        addr_t       addr;
        word_t       data;
        memop_size_t size;
        reg_addr_t   rf_waddr;
        instr_id_t   instr_id;
    } expect_t;

    // Reference model of the tags, the pending stores and the stage state
    logic [15:0] tag_valid;
    logic [23:0] tag_mem [16];
    sb_entry_t   sb_q [$];
    tl_state_e   mstate;
    expect_t     exp_q;
    logic        exp_valid = 1'b0;

    int checks = 0;
    int errors = 0;
    int test_errors = 0;
    int tests = 0;
    int fwd_seen = 0;
    int drain_seen = 0;
    int stall_seen = 0;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("MISMATCH %s: expected 0x%h, got 0x%h at %0t",
                     name, expected, actual, $time);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s at %0t", msg, $time);
        errors++;
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic summary(input int assert_fails);
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests, checks, errors, assert_fails);
    endtask

    // Youngest store to the same word decides between forward and conflict
    function automatic void predict_load(input addr_t addr, input memop_size_t size,
                                         output logic fwd, output logic conflict,
                                         output word_t data);
        fwd = 1'b0;
        conflict = 1'b0;
        data = '0;
        for (int i = sb_q.size() - 1; i >= 0; i--) begin
            if (sb_q[i].addr[31:2] == addr[31:2]) begin
                if (sb_q[i].addr == addr && sb_q[i].size == size) begin
                    fwd = 1'b1;
                    data = sb_q[i].data;
                end else begin
                    conflict = 1'b1;
                end
                return;
            end
        end
    endfunction

    // Oldest store leaves first
    function automatic expect_t predict_drain(input logic killed);
        expect_t e;
        e = '0;
        e.wr = !killed;
        e.addr = sb_q[0].addr;
        e.data = sb_q[0].data;
        e.size = sb_q[0].size;
        e.instr_id = sb_q[0].instr_id;
        return e;
    endfunction

    task automatic compare_mem();
        check_value("mem_o.rd", 32'(exp_q.rd), 32'(mem_o.rd));
        check_value("mem_o.wr", 32'(exp_q.wr), 32'(mem_o.wr));
        check_value("mem_o.rf_we", 32'(exp_q.rf_we), 32'(mem_o.rf_we));
        if (exp_q.rd) begin
            check_value("mem_o.addr", exp_q.addr, mem_o.addr);
            check_value("mem_o.index", 32'(exp_q.addr[7:4]), 32'(mem_o.index));
            check_value("mem_o.size", 32'(exp_q.size), 32'(mem_o.size));
            check_value("mem_o.sign_ext", 32'(exp_q.sign_ext), 32'(mem_o.sign_ext));
            check_value("mem_o.rf_waddr", 32'(exp_q.rf_waddr), 32'(mem_o.rf_waddr));
            check_value("mem_o.instr_id", 32'(exp_q.instr_id), 32'(mem_o.instr_id));
            check_value("mem_o.sb_hit", 32'(exp_q.sb_hit), 32'(mem_o.sb_hit));
            if (exp_q.sb_hit) begin
                check_value("mem_o.load_data", exp_q.data, mem_o.load_data);
            end
        end
        if (exp_q.wr) begin
            check_value("mem_o.addr", exp_q.addr, mem_o.addr);
            check_value("mem_o.index", 32'(exp_q.addr[7:4]), 32'(mem_o.index));
            check_value("mem_o.flush_data", exp_q.data, mem_o.flush_data);
            check_value("mem_o.size", 32'(exp_q.size), 32'(mem_o.size));
            check_value("mem_o.flush_size", 32'(exp_q.size), 32'(mem_o.flush_size));
            check_value("mem_o.instr_id", 32'(exp_q.instr_id), 32'(mem_o.instr_id));
        end
    endtask

    // Sampled mid-cycle once inputs and combinational outputs have settled
    always @(negedge clk_i) begin : model
        logic      fwd;
        logic      conflict;
        logic      hit;
        logic      full;
        logic      miss;
        logic      blocked;
        logic      drain;
        logic      hz;
        word_t     fwd_data;
        expect_t   nxt;
        sb_entry_t entry;
        tl_state_e next_state;
        if (!rst_n_i) begin
            sb_q.delete();
            tag_valid = '0;
            mstate = TL_IDLE;
            exp_q = '0;
            exp_valid = 1'b1;
        end else begin
            if (exp_valid) begin
                compare_mem();
            end
            // Activity seen on the DUT ports for the per-test checks
            if (pipeline_hazard_o === 1'b1) begin
                stall_seen++;
            end
            if (mem_o.wr === 1'b1) begin
                drain_seen++;
            end
            if (mem_o.rd === 1'b1 && mem_o.sb_hit === 1'b1) begin
                fwd_seen++;
            end
            predict_load(ex_req_i.addr, ex_req_i.size, fwd, conflict, fwd_data);
            hit = tag_valid[ex_req_i.addr[7:4]] &&
                  tag_mem[ex_req_i.addr[7:4]] == ex_req_i.addr[31:8];
            full = sb_q.size() == SB_ENTRIES;
            miss = ex_req_i.rd && !hit && !fwd && !conflict;
            blocked = (ex_req_i.wr && full) || (ex_req_i.rd && conflict);
            drain = 1'b0;
            next_state = mstate;
            hz = 1'b1;
            case (mstate)
                TL_IDLE: begin
                    hz = miss || blocked;
                    drain = !ex_req_i.rd && !ex_req_i.wr && store_permission_i &&
                            sb_q.size() > 0;
                    if (blocked) begin
                        next_state = HAZARD_SB_FULL;
                    end else if (miss) begin
                        next_state = HAZARD_DC_MISS;
                    end
                    check_value("mmu_miss_o", 32'(miss), 32'(mmu_miss_o));
                end
                HAZARD_DC_MISS: begin
                    if (mmu_data_rdy_i) begin
                        next_state = TL_IDLE;
                    end
                    check_value("mmu_miss_o", 32'd1, 32'(mmu_miss_o));
                    miss = 1'b1;
                end
                default: begin
                    drain = store_permission_i && sb_q.size() > 0;
                    if (!blocked) begin
                        next_state = TL_IDLE;
                    end
                    check_value("mmu_miss_o", 32'd0, 32'(mmu_miss_o));
                end
            endcase
            check_value("pipeline_hazard_o", 32'(hz), 32'(pipeline_hazard_o));
            if (miss) begin
                check_value("mmu_addr_o", {ex_req_i.addr[31:4], 4'h0}, mmu_addr_o);
            end
            nxt = '0;
            if (drain) begin
                nxt = predict_drain(kill_i);
            end else if (!hz) begin
                nxt.rd = ex_req_i.rd && !kill_i;
                nxt.rf_we = ex_req_i.rf_we && !kill_i;
                nxt.sb_hit = fwd;
                nxt.sign_ext = ex_req_i.sign_ext;
                nxt.addr = ex_req_i.addr;
                nxt.data = fwd_data;
                nxt.size = ex_req_i.size;
                nxt.rf_waddr = ex_req_i.rf_waddr;
                nxt.instr_id = ex_req_i.instr_id;
            end
            if (drain) begin
                sb_q.delete(0);
            end
            if (mstate == TL_IDLE && ex_req_i.wr && !full) begin
                entry.addr = ex_req_i.addr;
                entry.data = ex_req_i.data;
                entry.size = ex_req_i.size;
                entry.instr_id = ex_req_i.instr_id;
                sb_q.push_back(entry);
            end
            if (kill_i) begin
                sb_q.delete();
            end
            if (mmu_data_rdy_i) begin
                tag_valid[mmu_addr_i[7:4]] = 1'b1;
                tag_mem[mmu_addr_i[7:4]] = mmu_addr_i[31:8];
            end
            mstate = next_state;
            exp_q = nxt;
        end
    end

endmodule : tl_stage_checker

// File: tb/tl_stage_asserts.sv
`timescale 1ns/1ps

module tl_stage_asserts (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              mmu_miss_o,
    input  logic              mmu_data_rdy_i,
    input  tl_pkg::addr_t     mmu_addr_o,
    input  tl_pkg::mem_req_t  mem_o,
    input  tl_pkg::tl_state_e state_i
);
    import tl_pkg::*;

    int fail_count = 0;

    // Miss request and its line address stay up until the memory unit answers
    miss_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mmu_miss_o && !mmu_data_rdy_i |=> mmu_miss_o && $stable(mmu_addr_o))
    else begin
        $error("mmu_miss_o or mmu_addr_o changed before mmu_data_rdy_i");
        fail_count++;
    end

    reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i |=> !mem_o.rd && !mem_o.wr)
    else begin
        $error("mem_o carries rd or wr right after a reset cycle");
        fail_count++;
    end

    miss_state: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        state_i == HAZARD_DC_MISS |-> mmu_miss_o)
    else begin
        $error("state is HAZARD_DC_MISS while mmu_miss_o is low");
        fail_count++;
    end

endmodule : tl_stage_asserts

// File: source/tl_stage.sv
`timescale 1ns/1ps

module tl_stage (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             kill_i,
    // Execute side
    input  tl_pkg::ex_req_t  ex_req_i,
    input  logic             store_permission_i,
    // Memory stage side
    output tl_pkg::mem_req_t mem_o,
    output logic             pipeline_hazard_o,
    // Memory unit
    output logic             mmu_miss_o,
    output tl_pkg::addr_t    mmu_addr_o,
    input  logic             mmu_data_rdy_i,
    input  tl_pkg::addr_t    mmu_addr_i
);
    import tl_pkg::*;

    sb_entry_t push_entry;
    sb_entry_t sb_head;
    word_t     sb_fwd_data;
    logic      sb_valid;
    logic      sb_full;
    logic      sb_fwd_hit;
    logic      sb_conflict;
    logic      cache_hit;
    logic      push;
    logic      drain;
    logic      hazard;
    tl_state_e state;

    mem_req_t req_view;
    mem_req_t drain_view;
    mem_req_t stall_view;
    mem_req_t mem_d;
    mem_req_t mem_q;

    assign push_entry.addr     = ex_req_i.addr;
    assign push_entry.data     = ex_req_i.data;
    assign push_entry.size     = ex_req_i.size;
    assign push_entry.instr_id = ex_req_i.instr_id;

    dcache_tag_array dcache_tag_array_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .lookup_addr_i (ex_req_i.addr),
        .fill_i        (mmu_data_rdy_i),
        .fill_addr_i   (mmu_addr_i),
        .hit_o         (cache_hit)
    );

    store_buffer #(
        .DEPTH (SB_ENTRIES)
    ) store_buffer_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .kill_i       (kill_i),
        .push_i       (push),
        .push_entry_i (push_entry),
        .pop_i        (drain),
        .load_addr_i  (ex_req_i.addr),
        .load_size_i  (ex_req_i.size),
        .head_o       (sb_head),
        .valid_o      (sb_valid),
        .full_o       (sb_full),
        .fwd_hit_o    (sb_fwd_hit),
        .fwd_data_o   (sb_fwd_data),
        .conflict_o   (sb_conflict)
    );

    tl_hazard_ctrl tl_hazard_ctrl_i (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .req_rd_i           (ex_req_i.rd),
        .req_wr_i           (ex_req_i.wr),
        .req_addr_i         (ex_req_i.addr),
        .cache_hit_i        (cache_hit),
        .sb_fwd_hit_i       (sb_fwd_hit),
        .sb_conflict_i      (sb_conflict),
        .sb_full_i          (sb_full),
        .sb_valid_i         (sb_valid),
        .store_permission_i (store_permission_i),
        .mmu_data_rdy_i     (mmu_data_rdy_i),
        .state_o            (state),
        .hazard_o           (hazard),
        .push_o             (push),
        .drain_o            (drain),
        .mmu_miss_o         (mmu_miss_o),
        .mmu_addr_o         (mmu_addr_o)
    );

    // Load or bubble as it leaves the stage; stores only go into the buffer
    always_comb begin
        req_view.rd         = ex_req_i.rd && !kill_i;
        req_view.wr         = 1'b0;
        req_view.sign_ext   = ex_req_i.sign_ext;
        req_view.size       = ex_req_i.size;
        req_view.addr       = ex_req_i.addr;
        req_view.index      = get_index(ex_req_i.addr);
        req_view.sb_hit     = ex_req_i.rd && sb_fwd_hit;
        req_view.load_data  = sb_fwd_data;
        req_view.flush_data = sb_head.data;
        req_view.flush_size = sb_head.size;
        req_view.rf_we      = ex_req_i.rf_we && !kill_i;
        req_view.rf_waddr   = ex_req_i.rf_waddr;
        req_view.instr_id   = ex_req_i.instr_id;
    end

    // Oldest buffered store takes the output slot
    always_comb begin
        drain_view          = req_view;
        drain_view.rd       = 1'b0;
        drain_view.wr       = drain && !kill_i;
        drain_view.sb_hit   = 1'b0;
        drain_view.size     = sb_head.size;
        drain_view.addr     = sb_head.addr;
        drain_view.index    = get_index(sb_head.addr);
        drain_view.instr_id = sb_head.instr_id;
    end

    // Held request must not write back while the buffer drains
    always_comb begin
        stall_view       = drain_view;
        stall_view.rf_we = 1'b0;
    end

    assign mem_d = drain ? drain_view : req_view;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mem_q.rd     <= 1'b0;
            mem_q.wr     <= 1'b0;
            mem_q.rf_we  <= 1'b0;
            mem_q.sb_hit <= 1'b0;
        end else if (!hazard) begin
            mem_q <= mem_d;
        end else if (state == HAZARD_SB_FULL) begin
            mem_q <= stall_view;
        end else begin
            mem_q.rd     <= 1'b0;
            mem_q.wr     <= 1'b0;
            mem_q.rf_we  <= 1'b0;
            mem_q.sb_hit <= 1'b0;
        end
    end

    assign mem_o             = mem_q;
    assign pipeline_hazard_o = hazard;

endmodule : tl_stage

// File: source/tl_hazard_ctrl.sv
`timescale 1ns/1ps

module tl_hazard_ctrl (
    input  logic              clk_i,
    input  logic              rst_n_i,
    // Current request
    input  logic              req_rd_i,
    input  logic              req_wr_i,
    input  tl_pkg::addr_t     req_addr_i,
    // Lookup results
    input  logic              cache_hit_i,
    input  logic              sb_fwd_hit_i,
    input  logic              sb_conflict_i,
    input  logic              sb_full_i,
    input  logic              sb_valid_i,
    input  logic              store_permission_i,
    input  logic              mmu_data_rdy_i,
    output tl_pkg::tl_state_e state_o,
    output logic              hazard_o,
    output logic              push_o,
    output logic              drain_o,
    output logic              mmu_miss_o,
    output tl_pkg::addr_t     mmu_addr_o
);
    import tl_pkg::*;

    tl_state_e state_q;
    tl_state_e state_d;

    logic load_miss;
    logic sb_blocked;

    // A load served by forwarding never reaches the memory unit
    assign load_miss  = req_rd_i && !cache_hit_i && !sb_fwd_hit_i && !sb_conflict_i;
    assign sb_blocked = (req_wr_i && sb_full_i) || (req_rd_i && sb_conflict_i);

    // Upstream holds the request, so the line address stays stable during the miss
    assign mmu_addr_o = line_addr(req_addr_i);
    assign state_o    = state_q;

    always_comb begin
        state_d    = state_q;
        hazard_o   = 1'b0;
        push_o     = 1'b0;
        drain_o    = 1'b0;
        mmu_miss_o = 1'b0;
        unique case (state_q)
            TL_IDLE: begin
                hazard_o   = load_miss || sb_blocked;
                mmu_miss_o = load_miss;
                push_o     = req_wr_i && !sb_full_i;
                // Only a bubble leaves the output slot free for a drain
                drain_o    = !req_rd_i && !req_wr_i && store_permission_i && sb_valid_i;
                if (sb_blocked) begin
                    state_d = HAZARD_SB_FULL;
                end else if (load_miss) begin
                    state_d = HAZARD_DC_MISS;
                end
            end
            HAZARD_DC_MISS: begin
                hazard_o   = 1'b1;
                mmu_miss_o = 1'b1;
                if (mmu_data_rdy_i) begin
                    state_d = TL_IDLE;
                end
            end
            HAZARD_SB_FULL: begin
                hazard_o = 1'b1;
                drain_o  = store_permission_i && sb_valid_i;
                if (!sb_blocked) begin
                    state_d = TL_IDLE;
                end
            end
            default: begin
                state_d = TL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= TL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule : tl_hazard_ctrl

// File: source/store_buffer.sv
`timescale 1ns/1ps

module store_buffer #(
    parameter int DEPTH = tl_pkg::SB_ENTRIES
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                kill_i,
    // Enqueue side
    input  logic                push_i,
    input  tl_pkg::sb_entry_t   push_entry_i,
    // Drain side
    input  logic                pop_i,
    // Load search
    input  tl_pkg::addr_t       load_addr_i,
    input  tl_pkg::memop_size_t load_size_i,
    output tl_pkg::sb_entry_t   head_o,
    output logic                valid_o,
    output logic                full_o,
    output logic                fwd_hit_o,
    output tl_pkg::word_t       fwd_data_o,
    output logic                conflict_o
);
    import tl_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    sb_entry_t        entry_q [DEPTH];
    logic [DEPTH-1:0] valid_q;
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;

    logic push_en;
    logic pop_en;

    // Circular increment that also works for depths other than a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Tail slot still occupied means every slot is taken
    assign full_o  = valid_q[tail_q];
    assign valid_o = valid_q[head_q];
    assign head_o  = entry_q[head_q];

    assign push_en = push_i && !full_o;
    assign pop_en  = pop_i && valid_o;

    // Walk from oldest to youngest so the youngest matching store decides
    always_comb begin : search
        int unsigned idx;
        fwd_hit_o  = 1'b0;
        conflict_o = 1'b0;
        fwd_data_o = '0;
        for (int i = 0; i < DEPTH; i++) begin
            idx = (int'(head_q) + i) % DEPTH;
            if (valid_q[idx] && same_word(entry_q[idx].addr, load_addr_i)) begin
                if ((entry_q[idx].addr == load_addr_i) &&
                    (entry_q[idx].size == load_size_i)) begin
                    fwd_hit_o  = 1'b1;
                    conflict_o = 1'b0;
                    fwd_data_o = entry_q[idx].data;
                end else begin
                    // Same word but another shape, data cannot be forwarded
                    fwd_hit_o  = 1'b0;
                    conflict_o = 1'b1;
                    fwd_data_o = '0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || kill_i) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            if (pop_en) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= next_ptr(head_q);
            end
            if (push_en) begin
                valid_q[tail_q] <= 1'b1;
                tail_q          <= next_ptr(tail_q);
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk_i) begin
        if (push_en) begin
            entry_q[tail_q] <= push_entry_i;
        end
    end

endmodule : store_buffer

// File: source/dcache_tag_array.sv
`timescale 1ns/1ps

module dcache_tag_array (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  tl_pkg::addr_t lookup_addr_i,
    input  logic          fill_i,
    input  tl_pkg::addr_t fill_addr_i,
    output logic          hit_o
);
    import tl_pkg::*;

    // One valid bit and one tag per line, direct mapped
    logic [DCACHE_LINES-1:0] valid_q;
    dcache_tag_t             tag_q [DCACHE_LINES];

    dcache_index_t lookup_index;
    dcache_index_t fill_index;
    dcache_tag_t   lookup_tag;
    dcache_tag_t   fill_tag;

    assign lookup_index = get_index(lookup_addr_i);
    assign lookup_tag   = get_tag(lookup_addr_i);
    assign fill_index   = get_index(fill_addr_i);
    assign fill_tag     = get_tag(fill_addr_i);

    // Lookup is purely combinational
    assign hit_o = valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_q[fill_index] <= fill_tag;
        end
    end

endmodule : dcache_tag_array

// File: source/tl_pkg.sv
package tl_pkg;

    // Data path widths
    localparam int WORD_SIZE         = 32;
    localparam int WORD_OFFSET_SIZE  = 2;
    localparam int LINE_OFFSET_SIZE  = 4;
    localparam int DCACHE_INDEX_SIZE = 4;
    localparam int DCACHE_TAG_SIZE   = WORD_SIZE - DCACHE_INDEX_SIZE - LINE_OFFSET_SIZE;
    localparam int DCACHE_LINES      = 2 ** DCACHE_INDEX_SIZE;

    localparam int SB_ENTRIES    = 4;
    localparam int REG_ADDR_SIZE = 5;
    localparam int INSTR_ID_SIZE = 3;

    typedef logic [WORD_SIZE-1:0]         word_t;
    typedef logic [WORD_SIZE-1:0]         addr_t;
    typedef logic [DCACHE_INDEX_SIZE-1:0] dcache_index_t;
    typedef logic [DCACHE_TAG_SIZE-1:0]   dcache_tag_t;
    typedef logic [REG_ADDR_SIZE-1:0]     reg_addr_t;
    typedef logic [INSTR_ID_SIZE-1:0]     instr_id_t;

    // 0 byte, 1 half, 2 word
    typedef logic [1:0] memop_size_t;

    // Request coming from execute
    typedef struct packed {
        logic        rd;
        logic        wr;
        logic        sign_ext;
        memop_size_t size;
        addr_t       addr;
        word_t       data;
        logic        rf_we;
        reg_addr_t   rf_waddr;
        instr_id_t   instr_id;
    } ex_req_t;

    // Stage register toward the memory stage
    typedef struct packed {
        logic          rd;
        logic          wr;
        logic          sign_ext;
        memop_size_t   size;
        addr_t         addr;
        dcache_index_t index;
        logic          sb_hit;
        word_t         load_data;
        word_t         flush_data;
        memop_size_t   flush_size;
        logic          rf_we;
        reg_addr_t     rf_waddr;
        instr_id_t     instr_id;
    } mem_req_t;

    typedef struct packed {
        addr_t       addr;
        word_t       data;
        memop_size_t size;
        instr_id_t   instr_id;
    } sb_entry_t;

    typedef enum logic [1:0] {
        TL_IDLE,
        HAZARD_DC_MISS,
        HAZARD_SB_FULL
    } tl_state_e;

    function automatic dcache_index_t get_index(input addr_t addr);
        return addr[LINE_OFFSET_SIZE +: DCACHE_INDEX_SIZE];
    endfunction

    function automatic dcache_tag_t get_tag(input addr_t addr);
        return addr[WORD_SIZE-1 -: DCACHE_TAG_SIZE];
    endfunction

    // Line address with the byte offset cleared
    function automatic addr_t line_addr(input addr_t addr);
        return {addr[WORD_SIZE-1:LINE_OFFSET_SIZE], {LINE_OFFSET_SIZE{1'b0}}};
    endfunction

    function automatic logic same_word(input addr_t a, input addr_t b);
        return a[WORD_SIZE-1:WORD_OFFSET_SIZE] == b[WORD_SIZE-1:WORD_OFFSET_SIZE];
    endfunction

endpackage : tl_pkg
